// File: src.f
design/dpe_pkg.sv
design/dpe_if.sv
design/dpe_in_fifo.sv
design/dpe_arbiter.sv
design/dpe_router.sv
design/dpe.sv
bench/dpe_checker.sv
bench/dpe_tb.sv

// File: bench/dpe_tb.sv
// Testbench top for the data-plane engine
// Directed routing cases, random traffic on all ports, then a pause phase
// Stimulus and output tready come from one LFSR, so runs repeat exactly
`timescale 1ns/1ps
`default_nettype none

module dpe_tb import dpe_pkg::*; ();

   localparam int NO_DEST     = -1;                  // Frame is dropped
   localparam int HS_LIMIT    = 5000;                // Cycles per input word
   localparam int DRAIN_LIMIT = 20000;
   localparam int RAND_FRAMES = 25;                  // Per port

   logic              clk;
   logic              rst_n;
   logic              pause;
   logic              is_idle;
   logic              quiet;                         // Checker expects no output
   logic              random_ready;
   logic [DATA_W-1:0] rx_tdata  [NUM_PORTS];
   logic              rx_tlast  [NUM_PORTS];
   logic              rx_tvalid [NUM_PORTS];
   logic              rx_tready [NUM_PORTS];
   logic [DATA_W-1:0] tx_tdata  [NUM_PORTS];
   logic              tx_tlast  [NUM_PORTS];
   logic              tx_tvalid [NUM_PORTS];
   logic              tx_tready [NUM_PORTS];
   logic [31:0]       lfsr;
   int                seq_no [NUM_PORTS];            // Per-source tag counter
   int                timeouts;
   event              stop_run;

   dpe dut_i (
      .clk(clk), .rst_n(rst_n), .pause(pause), .is_idle(is_idle),
      .rx_cpu_tdata(rx_tdata[PORT_CPU]), .rx_cpu_tlast(rx_tlast[PORT_CPU]),
      .rx_cpu_tvalid(rx_tvalid[PORT_CPU]), .rx_cpu_tready(rx_tready[PORT_CPU]),
      .tx_cpu_tdata(tx_tdata[PORT_CPU]), .tx_cpu_tlast(tx_tlast[PORT_CPU]),
      .tx_cpu_tvalid(tx_tvalid[PORT_CPU]), .tx_cpu_tready(tx_tready[PORT_CPU]),
      .rx_eth_1_tdata(rx_tdata[PORT_ETH_1]), .rx_eth_1_tlast(rx_tlast[PORT_ETH_1]),
      .rx_eth_1_tvalid(rx_tvalid[PORT_ETH_1]), .rx_eth_1_tready(rx_tready[PORT_ETH_1]),
      .tx_eth_1_tdata(tx_tdata[PORT_ETH_1]), .tx_eth_1_tlast(tx_tlast[PORT_ETH_1]),
      .tx_eth_1_tvalid(tx_tvalid[PORT_ETH_1]), .tx_eth_1_tready(tx_tready[PORT_ETH_1]),
      .rx_eth_2_tdata(rx_tdata[PORT_ETH_2]), .rx_eth_2_tlast(rx_tlast[PORT_ETH_2]),
      .rx_eth_2_tvalid(rx_tvalid[PORT_ETH_2]), .rx_eth_2_tready(rx_tready[PORT_ETH_2]),
      .tx_eth_2_tdata(tx_tdata[PORT_ETH_2]), .tx_eth_2_tlast(tx_tlast[PORT_ETH_2]),
      .tx_eth_2_tvalid(tx_tvalid[PORT_ETH_2]), .tx_eth_2_tready(tx_tready[PORT_ETH_2])
   );

   dpe_checker chk_i (
      .clk(clk), .rst_n(rst_n), .quiet(quiet), .is_idle(is_idle), .rx_tready(rx_tready),
      .tx_tdata(tx_tdata), .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid), .tx_tready(tx_tready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                         // 8 ns period
   end

//============================================================
// Random source and reference model
//============================================================
   // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // Routing rules applied to the first word of a frame
   function automatic int expected_dest(input int src, input hdr_word_u hdr);
      if (src == int'(PORT_CPU)) begin
         if (hdr.cpu.out_port == 8'd1)
            return int'(PORT_ETH_1);
         if (hdr.cpu.out_port == 8'd2)
            return int'(PORT_ETH_2);
         return NO_DEST;                             // Names no Ethernet port
      end
      if (hdr.eth.ethertype == ETYPE_IPV4)
         return (src == int'(PORT_ETH_1)) ? int'(PORT_ETH_2) : int'(PORT_ETH_1);
      return int'(PORT_CPU);
   endfunction

   function automatic hdr_word_u eth_header(input logic [15:0] etype);
      hdr_word_u h;
      h.eth.ethertype = etype;
      h.eth.rest      = 16'(rand_bits(16));
      return h;
   endfunction

   function automatic hdr_word_u cpu_header(input logic [7:0] out_port);
      hdr_word_u h;
      h.cpu.out_port = out_port;
      h.cpu.reserved = 24'(rand_bits(24));
      return h;
   endfunction

//============================================================
// Drivers and waits
//============================================================
   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      timeouts++;
      -> stop_run;
   endtask

   // Called just after a rising edge, returns just after the last transfer
   task automatic send_frame(input int p, input hdr_word_u hdr, input int len);
      logic [DATA_W-1:0] words [10];
      logic              ok;
      int                dst;
      int                n;
      words[0] = hdr;
      words[1] = {8'(p), 8'h5a, 16'(seq_no[p])};    // Tag word
      seq_no[p]++;
      for (int i = 2; i < len; i++)
         words[i] = rand_bits(32);
      dst = expected_dest(p, hdr);
      if (dst != NO_DEST)
         for (int i = 0; i < len; i++)
            chk_i.add_expected(dst, p, words[i], i == len - 1);
      ok = 1'b1;
      for (int i = 0; i < len && ok; i++) begin
         rx_tdata[p]  <= words[i];
         rx_tlast[p]  <= (i == len - 1);
         rx_tvalid[p] <= 1'b1;
         n = 0;
         @(posedge clk);
         while (!rx_tready[p] && n < HS_LIMIT) begin
            n++;
            @(posedge clk);
         end
         if (!rx_tready[p]) begin
            report_timeout($sformatf("input port %0d never accepted a word", p));
            ok = 1'b0;
         end
      end
      rx_tvalid[p] <= 1'b0;
   endtask

   task automatic random_traffic(input int p, input int count);
      hdr_word_u hdr;
      int        len;
      for (int f = 0; f < count; f++) begin
         len = 2 + int'(rand_bits(3));               // 2 to 9 words
         if (p == int'(PORT_CPU))
            hdr = (rand_bits(3) == 0) ? cpu_header(8'(rand_bits(8)))
                                      : cpu_header(8'(rand_bits(2)));
         else if (rand_bits(1) == 0)
            hdr = eth_header(ETYPE_IPV4);
         else
            hdr = eth_header(rand_bits(1) ? 16'h86dd : 16'h0806);
         send_frame(p, hdr, len);
         repeat (rand_bits(2)) @(posedge clk);       // Gap between frames
      end
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      @(posedge clk);
      while (!(chk_i.pending_frames == 0 && is_idle) && n < DRAIN_LIMIT) begin
         n++;
         @(posedge clk);
      end
      if (!(chk_i.pending_frames == 0 && is_idle))
         report_timeout({what, " did not drain"});
   endtask

   initial begin
      for (int p = 0; p < NUM_PORTS; p++)
         tx_tready[p] = 1'b1;
      forever begin
         @(posedge clk);
         for (int p = 0; p < NUM_PORTS; p++)
            tx_tready[p] <= random_ready ? (rand_bits(2) != 0) : 1'b1;  // 3 in 4 ready
      end
   end

//============================================================
// Test sequence
//============================================================
   task automatic run_tests();
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      chk_i.check_reset_state();

      send_frame(PORT_ETH_1, eth_header(ETYPE_IPV4), 4);  // Bridged
      send_frame(PORT_ETH_2, eth_header(ETYPE_IPV4), 3);
      send_frame(PORT_ETH_1, eth_header(16'h86dd), 5);    // To CPU
      send_frame(PORT_ETH_2, eth_header(16'h0806), 2);
      send_frame(PORT_CPU, cpu_header(8'd1), 6);
      send_frame(PORT_CPU, cpu_header(8'd2), 2);
      send_frame(PORT_CPU, cpu_header(8'd0), 4);          // Dropped
      send_frame(PORT_CPU, cpu_header(8'd3), 3);
      send_frame(PORT_CPU, cpu_header(8'hff), 9);
      wait_drain("directed frames");

      random_ready = 1'b1;
      fork
         random_traffic(PORT_CPU, RAND_FRAMES);
         random_traffic(PORT_ETH_1, RAND_FRAMES);
         random_traffic(PORT_ETH_2, RAND_FRAMES);
      join
      wait_drain("random traffic");
      random_ready = 1'b0;

      pause <= 1'b1;
      quiet <= 1'b1;
      repeat (2) @(posedge clk);
      chk_i.check_idle(1'b1, "pause held, nothing offered");
      fork
         send_frame(PORT_CPU, cpu_header(8'd2), 5);
         send_frame(PORT_ETH_1, eth_header(ETYPE_IPV4), 7);
         send_frame(PORT_ETH_2, eth_header(16'h88cc), 9);
      join
      @(posedge clk);
      chk_i.check_idle(1'b0, "frames buffered under pause");
      repeat (20) @(posedge clk);                    // Outputs must stay silent
      pause <= 1'b0;
      quiet <= 1'b0;
      wait_drain("frames after pause release");
   endtask

   initial begin
      lfsr         = 32'h816d;
      rst_n        = 1'b0;
      pause        = 1'b0;
      quiet        = 1'b0;
      random_ready = 1'b0;
      timeouts     = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         rx_tdata[p]  = '0;
         rx_tlast[p]  = 1'b0;
         rx_tvalid[p] = 1'b0;
         seq_no[p]    = 0;
      end
      fork
         run_tests();
         @(stop_run);
      join_any
      disable fork;
      chk_i.report_leftover();
      $display("frames checked %0d, value errors %0d, other errors %0d, timeouts %0d",
               chk_i.frames_seen, chk_i.value_errs, chk_i.other_errs, timeouts);
      if (chk_i.value_errs == 0 && chk_i.other_errs == 0 && timeouts == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/dpe_checker.sv
// Output checker for the DPE testbench
// Expected frames are queued per destination and source through add_expected
// The second word of every frame is a tag whose top byte names the source port
`timescale 1ns/1ps
`default_nettype none

module dpe_checker import dpe_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              quiet,                  // No output word allowed
   input  logic              is_idle,
   input  logic              rx_tready [NUM_PORTS],
   input  logic [DATA_W-1:0] tx_tdata  [NUM_PORTS],
   input  logic              tx_tlast  [NUM_PORTS],
   input  logic              tx_tvalid [NUM_PORTS],
   input  logic              tx_tready [NUM_PORTS]
);

   localparam int MAX_LEN = 16;                      // Longest frame held

   logic [DATA_W:0]   exp_q [NUM_PORTS*NUM_PORTS][$];  // {tlast, tdata}, dst*3+src
   logic [DATA_W-1:0] rx_buf [NUM_PORTS][MAX_LEN];     // Frame being received
   int                rx_len [NUM_PORTS];
   int                value_errs = 0;
   int                other_errs = 0;
   int                pending_frames = 0;              // Expected, not yet seen
   int                frames_seen = 0;

   function automatic string port_name(input int p);
      case (p)
         0:       return "cpu";
         1:       return "eth_1";
         default: return "eth_2";
      endcase
   endfunction

//============================================================
// Expectations from the stimulus side
//============================================================
   task automatic add_expected(input int dst, input int src,
                               input logic [DATA_W-1:0] word, input logic last);
      exp_q[dst*NUM_PORTS + src].push_back({last, word});
      if (last)
         pending_frames++;
   endtask

   task automatic check_idle(input logic exp, input string when);
      if (is_idle !== exp) begin
         $display("Error: is_idle got %h expected %h (%s)", is_idle, exp, when);
         value_errs++;
      end
   endtask

   task automatic check_reset_state();
      check_idle(1'b1, "after reset");
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (rx_tready[p] !== 1'b1) begin
            $display("Error: rx_%s_tready got %h expected 1", port_name(p), rx_tready[p]);
            value_errs++;
         end
         if (tx_tvalid[p] !== 1'b0) begin
            $display("Error: tx_%s_tvalid got %h expected 0", port_name(p), tx_tvalid[p]);
            value_errs++;
         end
      end
   endtask

//============================================================
// Frame compare
//============================================================
   task automatic check_frame(input int p);
      logic [DATA_W-1:0] tag;
      logic [DATA_W:0]   e;
      logic              got_last;
      logic              done;
      int                src;
      int                idx;
      int                i;
      frames_seen++;
      if (rx_len[p] < 2 || rx_len[p] > MAX_LEN) begin
         $display("Frame of %0d words on tx_%s has an impossible length", rx_len[p],
                  port_name(p));
         other_errs++;
         return;
      end
      tag = rx_buf[p][1];
      src = int'(tag[31:24]);                        // Source port from the tag
      if (src >= NUM_PORTS) begin
         $display("Frame on tx_%s carries a tag with no valid source", port_name(p));
         other_errs++;
         return;
      end
      idx = p*NUM_PORTS + src;
      if (exp_q[idx].size() == 0) begin
         $display("Frame from %s came out on tx_%s but none was expected there",
                  port_name(src), port_name(p));
         other_errs++;
         return;
      end
      pending_frames--;
      i    = 0;
      done = 1'b0;
      while (!done && exp_q[idx].size() > 0) begin
         e = exp_q[idx].pop_front();
         if (i < rx_len[p]) begin
            got_last = (i == rx_len[p] - 1);
            if (rx_buf[p][i] !== e[DATA_W-1:0]) begin
               $display("Error: tx_%s_tdata word %0d got %h expected %h", port_name(p), i,
                        rx_buf[p][i], e[DATA_W-1:0]);
               value_errs++;
            end
            if (got_last !== e[DATA_W]) begin
               $display("Error: tx_%s_tlast word %0d got %h expected %h", port_name(p), i,
                        got_last, e[DATA_W]);
               value_errs++;
            end
         end
         done = e[DATA_W];
         i++;
      end
      if (i != rx_len[p]) begin
         $display("Frame from %s on tx_%s had %0d words instead of %0d", port_name(src),
                  port_name(p), rx_len[p], i);
         other_errs++;
      end
   endtask

   always @(posedge clk) begin
      if (rst_n) begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (quiet && tx_tvalid[p]) begin
               $display("Output tx_%s offered a word while pause was held", port_name(p));
               other_errs++;
            end
            if (tx_tvalid[p] && tx_tready[p]) begin   // Word transfers at this edge
               if (rx_len[p] < MAX_LEN)
                  rx_buf[p][rx_len[p]] = tx_tdata[p];
               rx_len[p]++;
               if (tx_tlast[p]) begin
                  check_frame(p);
                  rx_len[p] = 0;
               end
            end
         end
      end
   end

   task automatic report_leftover();
      int left;
      for (int idx = 0; idx < NUM_PORTS*NUM_PORTS; idx++) begin
         left = 0;
         for (int k = 0; k < exp_q[idx].size(); k++)
            if (exp_q[idx][k][DATA_W])
               left++;
         if (left != 0) begin
            $display("%0d frame(s) from %s to %s never came out", left,
                     port_name(idx % NUM_PORTS), port_name(idx / NUM_PORTS));
            other_errs += left;
         end
      end
      for (int p = 0; p < NUM_PORTS; p++)
         if (rx_len[p] != 0) begin
            $display("Output tx_%s stopped in the middle of a frame", port_name(p));
            other_errs++;
         end
   endtask

   initial begin
      for (int p = 0; p < NUM_PORTS; p++)
         rx_len[p] = 0;
   end

endmodule

`default_nettype wire

// File: design/dpe.sv
// Data-plane engine top, CPU port and two Ethernet ports
// Frames are whole 32-bit words and at least two words long
// Latency varies with arbitration, a frame ends with its tx tlast transfer
`timescale 1ns/1ps
`default_nettype none

module dpe import dpe_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              pause,          // Blocks new grants
   output logic              is_idle,        // No frame anywhere inside

   // CPU port
   input  logic [DATA_W-1:0] rx_cpu_tdata,
   input  logic              rx_cpu_tlast,
   input  logic              rx_cpu_tvalid,
   output logic              rx_cpu_tready,
   output logic [DATA_W-1:0] tx_cpu_tdata,
   output logic              tx_cpu_tlast,
   output logic              tx_cpu_tvalid,
   input  logic              tx_cpu_tready,

   // Ethernet 1
   input  logic [DATA_W-1:0] rx_eth_1_tdata,
   input  logic              rx_eth_1_tlast,
   input  logic              rx_eth_1_tvalid,
   output logic              rx_eth_1_tready,
   output logic [DATA_W-1:0] tx_eth_1_tdata,
   output logic              tx_eth_1_tlast,
   output logic              tx_eth_1_tvalid,
   input  logic              tx_eth_1_tready,

   // Ethernet 2
   input  logic [DATA_W-1:0] rx_eth_2_tdata,
   input  logic              rx_eth_2_tlast,
   input  logic              rx_eth_2_tvalid,
   output logic              rx_eth_2_tready,
   output logic [DATA_W-1:0] tx_eth_2_tdata,
   output logic              tx_eth_2_tlast,
   output logic              tx_eth_2_tvalid,
   input  logic              tx_eth_2_tready
);

   dpe_if fifo_q_cpu ();
   dpe_if fifo_q_eth_1 ();
   dpe_if fifo_q_eth_2 ();
   dpe_if merged ();

   logic [NUM_PORTS-1:0] fifo_empty;
   port_id_t             src_port;
   logic                 arb_busy;
   logic                 rtr_holding;
   logic [DATA_W-1:0]    tx_tdata  [NUM_PORTS];   // Router outputs by port number
   logic                 tx_tlast  [NUM_PORTS];
   logic                 tx_tvalid [NUM_PORTS];
   logic                 tx_tready [NUM_PORTS];

//============================================================
// Input buffers
//============================================================
   dpe_in_fifo u_fifo_cpu (
      .clk(clk), .rst_n(rst_n),
      .in_tdata(rx_cpu_tdata), .in_tlast(rx_cpu_tlast),
      .in_tvalid(rx_cpu_tvalid), .in_tready(rx_cpu_tready),
      .fifo_q(fifo_q_cpu), .empty(fifo_empty[PORT_CPU])
   );

   dpe_in_fifo u_fifo_eth_1 (
      .clk(clk), .rst_n(rst_n),
      .in_tdata(rx_eth_1_tdata), .in_tlast(rx_eth_1_tlast),
      .in_tvalid(rx_eth_1_tvalid), .in_tready(rx_eth_1_tready),
      .fifo_q(fifo_q_eth_1), .empty(fifo_empty[PORT_ETH_1])
   );

   dpe_in_fifo u_fifo_eth_2 (
      .clk(clk), .rst_n(rst_n),
      .in_tdata(rx_eth_2_tdata), .in_tlast(rx_eth_2_tlast),
      .in_tvalid(rx_eth_2_tvalid), .in_tready(rx_eth_2_tready),
      .fifo_q(fifo_q_eth_2), .empty(fifo_empty[PORT_ETH_2])
   );

//============================================================
// Arbiter and router
//============================================================
   dpe_arbiter u_arbiter (
      .clk(clk), .rst_n(rst_n), .pause(pause),
      .fifo_1(fifo_q_cpu), .fifo_2(fifo_q_eth_1), .fifo_3(fifo_q_eth_2),
      .merged(merged), .src_port(src_port), .busy(arb_busy)
   );

   dpe_router u_router (
      .clk(clk), .rst_n(rst_n),
      .merged(merged), .src_port(src_port),
      .out_tdata(tx_tdata), .out_tlast(tx_tlast),
      .out_tvalid(tx_tvalid), .out_tready(tx_tready),
      .holding(rtr_holding)
   );

   assign tx_tready[PORT_CPU]   = tx_cpu_tready;
   assign tx_tready[PORT_ETH_1] = tx_eth_1_tready;
   assign tx_tready[PORT_ETH_2] = tx_eth_2_tready;

   assign tx_cpu_tdata    = tx_tdata[PORT_CPU];
   assign tx_cpu_tlast    = tx_tlast[PORT_CPU];
   assign tx_cpu_tvalid   = tx_tvalid[PORT_CPU];
   assign tx_eth_1_tdata  = tx_tdata[PORT_ETH_1];
   assign tx_eth_1_tlast  = tx_tlast[PORT_ETH_1];
   assign tx_eth_1_tvalid = tx_tvalid[PORT_ETH_1];
   assign tx_eth_2_tdata  = tx_tdata[PORT_ETH_2];
   assign tx_eth_2_tlast  = tx_tlast[PORT_ETH_2];
   assign tx_eth_2_tvalid = tx_tvalid[PORT_ETH_2];

   assign is_idle = !arb_busy && !rtr_holding && (&fifo_empty);  // Nothing buffered or moving

endmodule

`default_nettype wire

// File: design/dpe_router.sv
// Header decode and output steering for the merged stream
// Destination is fixed by the first word and held for the whole frame
// One-word output register, so every output sees one cycle of latency
// Dropped frames drain at one word per cycle and reach no output
`timescale 1ns/1ps
`default_nettype none

module dpe_router import dpe_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   dpe_if.dst                merged,
   input  port_id_t          src_port,
   output logic [DATA_W-1:0] out_tdata  [NUM_PORTS],
   output logic              out_tlast  [NUM_PORTS],
   output logic              out_tvalid [NUM_PORTS],
   input  logic              out_tready [NUM_PORTS],
   output logic              holding
);

   hdr_word_u         hdr;          // First word seen two ways
   port_id_t          dest_c;       // Decoded from current word
   logic              drop_c;
   port_id_t          dest_q;       // Latched for the frame
   logic              drop_q;
   port_id_t          cur_dest;
   logic              cur_drop;
   logic              in_frame_q;   // Past the first word
   logic              out_valid_q;
   logic [DATA_W-1:0] out_data_q;
   logic              out_last_q;
   port_id_t          out_dest_q;
   logic              out_free;     // Output register can take a word
   logic              xfer;
   logic              accept;

//============================================================
// Header decode
//============================================================
   assign hdr = merged.tdata;

   always_comb begin
      dest_c = PORT_CPU;                          // Non-IPv4 Ethernet goes to CPU
      drop_c = 1'b0;
      if (src_port == PORT_ETH_1 || src_port == PORT_ETH_2) begin
         if (hdr.eth.ethertype == ETYPE_IPV4)
            dest_c = (src_port == PORT_ETH_1) ? PORT_ETH_2 : PORT_ETH_1;  // Bridge
      end else begin
         if (hdr.cpu.out_port == 8'(PORT_ETH_1))
            dest_c = PORT_ETH_1;
         else if (hdr.cpu.out_port == 8'(PORT_ETH_2))
            dest_c = PORT_ETH_2;
         else
            drop_c = 1'b1;                        // No such Ethernet port
      end
   end

   assign cur_dest = in_frame_q ? dest_q : dest_c;
   assign cur_drop = in_frame_q ? drop_q : drop_c;

//============================================================
// Handshake and frame tracking
//============================================================
   assign out_free     = !out_valid_q || out_tready[out_dest_q];
   assign merged.tready = cur_drop || out_free;   // Drops never stall
   assign xfer         = merged.tvalid && merged.tready;
   assign accept       = xfer && !cur_drop;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_frame_q <= 1'b0;
         dest_q     <= PORT_CPU;
         drop_q     <= 1'b0;
      end else if (xfer) begin
         if (!in_frame_q) begin
            dest_q <= dest_c;                     // Latch on first word
            drop_q <= drop_c;
         end
         in_frame_q <= !merged.tlast;
      end
   end

//============================================================
// Output register
//============================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid_q <= 1'b0;
         out_dest_q  <= PORT_CPU;
      end else if (accept) begin
         out_valid_q <= 1'b1;
         out_dest_q  <= cur_dest;
      end else if (out_valid_q && out_tready[out_dest_q]) begin
         out_valid_q <= 1'b0;                     // Drained, nothing new
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_data_q <= merged.tdata;
         out_last_q <= merged.tlast;
      end
   end

   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         out_tvalid[p] = out_valid_q && (out_dest_q == port_id_t'(p));  // Chosen port only
         out_tdata[p]  = out_data_q;
         out_tlast[p]  = out_last_q;
      end
   end

   assign holding = in_frame_q || out_valid_q;

endmodule

`default_nettype wire

// File: design/dpe_arbiter.sv
// Frame-level round-robin arbiter over the three input FIFOs
// Grant is taken from the idle state only, so frames never interleave
// pause blocks new grants and never cuts a frame in flight
`timescale 1ns/1ps
`default_nettype none

module dpe_arbiter import dpe_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     pause,
   dpe_if.dst       fifo_1,    // CPU
   dpe_if.dst       fifo_2,    // ETH_1
   dpe_if.dst       fifo_3,    // ETH_2
   dpe_if.src       merged,
   output port_id_t src_port,
   output logic     busy
);

   logic [NUM_PORTS-1:0] in_valid;
   logic [DATA_W-1:0]    in_data [NUM_PORTS];
   logic [NUM_PORTS-1:0] in_last;
   logic [NUM_PORTS-1:0] take;       // tready back to each FIFO
   port_id_t             grant_q;    // Port owning merged
   port_id_t             last_q;     // Last port served
   port_id_t             next_port;  // Round-robin winner
   logic                 found;      // Any input waiting
   logic                 busy_q;
   int unsigned          idx;

//============================================================
// Gather inputs by port number
//============================================================
   assign in_valid[PORT_CPU]   = fifo_1.tvalid;
   assign in_valid[PORT_ETH_1] = fifo_2.tvalid;
   assign in_valid[PORT_ETH_2] = fifo_3.tvalid;
   assign in_data[PORT_CPU]    = fifo_1.tdata;
   assign in_data[PORT_ETH_1]  = fifo_2.tdata;
   assign in_data[PORT_ETH_2]  = fifo_3.tdata;
   assign in_last[PORT_CPU]    = fifo_1.tlast;
   assign in_last[PORT_ETH_1]  = fifo_2.tlast;
   assign in_last[PORT_ETH_2]  = fifo_3.tlast;

   // Search downward so the nearest port after last_q is kept
   always_comb begin
      next_port = last_q;
      found     = 1'b0;
      idx       = 0;
      for (int k = NUM_PORTS; k > 0; k--) begin
         idx = (int'(last_q) + k) % NUM_PORTS;
         if (in_valid[idx]) begin
            next_port = port_id_t'(idx);
            found     = 1'b1;
         end
      end
   end

//============================================================
// Grant state
//============================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q  <= 1'b0;
         grant_q <= PORT_CPU;
         last_q  <= PORT_ETH_2;                   // CPU searched first
      end else if (!busy_q) begin
         if (found && !pause) begin
            busy_q  <= 1'b1;
            grant_q <= next_port;
         end
      end else if (merged.tvalid && merged.tready && merged.tlast) begin
         busy_q <= 1'b0;                          // Frame done, back to idle
         last_q <= grant_q;
      end
   end

//============================================================
// Merged stream, pass-through of the granted FIFO
//============================================================
   assign merged.tvalid = busy_q && in_valid[grant_q];
   assign merged.tdata  = in_data[grant_q];
   assign merged.tlast  = in_last[grant_q];

   always_comb begin
      take          = '0;
      take[grant_q] = busy_q && merged.tready;
   end

   assign fifo_1.tready = take[PORT_CPU];
   assign fifo_2.tready = take[PORT_ETH_1];
   assign fifo_3.tready = take[PORT_ETH_2];

   assign src_port = grant_q;
   assign busy     = busy_q;

endmodule

`default_nettype wire

// File: design/dpe_in_fifo.sv
// Input frame buffer, one per port
// Word written at an edge is visible on fifo_q from the next cycle
// No write bypass when full, in_tready drops for the whole full state
`timescale 1ns/1ps
`default_nettype none

module dpe_in_fifo import dpe_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [DATA_W-1:0] in_tdata,
   input  logic              in_tlast,
   input  logic              in_tvalid,
   output logic              in_tready,
   dpe_if.src                fifo_q,
   output logic              empty
);

   logic [DATA_W:0]    mem [FIFO_DEPTH];  // tlast kept in the top bit
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [CNT_W-1:0]   count;             // Words held
   logic               wr_en;
   logic               rd_en;

//============================================================
// Handshakes
//============================================================
   assign in_tready = (count != CNT_W'(FIFO_DEPTH));   // Low only when full
   assign empty     = (count == '0);
   assign wr_en     = in_tvalid && in_tready;
   assign rd_en     = fifo_q.tvalid && fifo_q.tready;

   assign fifo_q.tvalid = !empty;
   assign {fifo_q.tlast, fifo_q.tdata} = mem[rd_ptr];  // Head word, async read

//============================================================
// Storage and pointers
//============================================================
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= {in_tlast, in_tdata};
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;                   // Wraps at FIFO_DEPTH
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;            // Write only
            2'b01:   count <= count - 1'b1;            // Read only
            default: count <= count;                   // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/dpe_if.sv
// Word stream between DPE blocks, valid/ready handshake
// Transfer on a rising edge with tvalid and tready both high
// Source keeps tdata, tlast and tvalid stable until the transfer
`timescale 1ns/1ps
`default_nettype none

interface dpe_if import dpe_pkg::*; ();

   logic [DATA_W-1:0] tdata;   // Payload word
   logic              tlast;   // Last word of frame
   logic              tvalid;  // Word offered
   logic              tready;  // Word taken

   modport src (
      output tdata, tlast, tvalid,
      input  tready
   );

   modport dst (
      input  tdata, tlast, tvalid,
      output tready
   );

endinterface

`default_nettype wire

// File: design/dpe_pkg.sv
// Shared definitions for the data-plane engine
// Port numbers double as array indices in the arbiter and router
// FIFO_DEPTH must stay a power of two, the pointers wrap on their own width
`default_nettype none

package dpe_pkg;

//============================================================
// Ports and stream width
//============================================================
   localparam int NUM_PORTS = 3;                    // CPU plus two Ethernet ports
   localparam int DATA_W    = 32;                   // Stream word width

   typedef logic [1:0] port_id_t;                   // Packed port number

   localparam port_id_t PORT_CPU   = 2'd0;
   localparam port_id_t PORT_ETH_1 = 2'd1;
   localparam port_id_t PORT_ETH_2 = 2'd2;

//============================================================
// Input buffering
//============================================================
   localparam int FIFO_DEPTH = 16;                  // Words per input FIFO
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // Pointer width
   localparam int CNT_W      = FIFO_AW + 1;         // Count reaches FIFO_DEPTH

//============================================================
// Header decoding
//============================================================
   localparam logic [15:0] ETYPE_IPV4 = 16'h0800;

   // First word of a frame from an Ethernet port
   typedef struct packed {
      logic [15:0] ethertype;                       // Compared to ETYPE_IPV4
      logic [15:0] rest;
   } eth_hdr_t;

   // First word of a frame from the CPU
   typedef struct packed {
      logic [7:0]  out_port;                        // Target Ethernet port number
      logic [23:0] reserved;
   } cpu_hdr_t;

   typedef union packed {
      eth_hdr_t eth;                                // View for ETH sources
      cpu_hdr_t cpu;                                // View for CPU source
   } hdr_word_u;

endpackage

`default_nettype wire
